// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int word_width = 16;

    typedef logic [word_width-1:0] word_t;
    typedef logic [1:0]            reg_idx_t;

    // Opcode 0 stays unused. An all-zero word then decodes as a bubble.
    typedef enum logic [3:0] {
        alu_r = 4'd1,
        adi   = 4'd2,
        lwd   = 4'd3,
        swd   = 4'd4,
        beq   = 4'd5,
        bne   = 4'd6,
        jmp   = 4'd7,
        hlt   = 4'd8
    } opcode_t;

    typedef enum logic [5:0] {
        f_add = 6'd0,
        f_sub = 6'd1,
        f_and = 6'd2,
        f_or  = 6'd3
    } func_t;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields.
    localparam int op_lsb        = 12;
    localparam int rs_lsb        = 10;
    localparam int rt_lsb        = 8;
    localparam int rd_lsb        = 6;
    localparam int func_lsb      = 0;
    localparam int imm_width     = 8;  // Sign-extended.
    localparam int jtarget_width = 12;

    ////////////////////////////////////////////////////////////////////////////
    // Stage payloads.
    typedef struct packed {
        word_t instr;
        word_t next_pc;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     mem_to_reg;
        logic     alu_src;    // Second operand is imm.
        logic     is_branch;
        logic     branch_ne;
        logic     is_jump;
        logic     is_halt;
        func_t    alu_op;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    rs_value;
        word_t    rt_value;
        word_t    imm;        // Full jump target for jmp.
        word_t    next_pc;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    target_address;
        logic     b_cond;
        logic     branch_taken;
        word_t    alu_result;
        word_t    r_data2;
        reg_idx_t rd;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     mem_to_reg;
        logic     is_halt;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    result;
        reg_idx_t rd;
        logic     reg_write;
        logic     is_halt;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: rtl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int             word_width = cpu_pkg::word_width,
    parameter cpu_pkg::word_t reset_pc   = '0
) (
    input  logic           clk,
    input  logic           reset_n,
    output logic           mem_req,
    output logic           mem_write,
    output cpu_pkg::word_t mem_addr,
    output cpu_pkg::word_t mem_wdata,
    input  cpu_pkg::word_t mem_rdata,
    output logic           halted,
    output cpu_pkg::word_t retired_count
);
    import cpu_pkg::*;

    mem_bus_if ibus ();
    mem_bus_if dbus ();

    if_id_t  if_id_d;
    if_id_t  if_id_q;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    logic  fetch_valid;
    logic  stall;
    logic  redirect;
    logic  halt_seen;
    logic  if_id_flush;
    logic  id_ex_flush;
    word_t redirect_pc;

    ////////////////////////////////////////////////////////////////////////////
    // IF and ID.
    fetch_unit #(.word_width(word_width), .reset_pc(reset_pc)) u_fetch (
        .clk, .reset_n, .stall, .redirect, .redirect_pc, .halt_seen,
        .ibus(ibus.requester), .fetched(if_id_d), .fetch_valid
    );

    // A lost fetch grant becomes a bubble unless the front is held.
    assign if_id_flush = redirect || (!fetch_valid && !stall);

    pipe_stage_reg #(.payload_t(if_id_t), .bubble('0)) if_id (
        .clk, .reset_n, .stall, .flush(if_id_flush), .d(if_id_d), .q(if_id_q)
    );

    decode_unit #(.word_width(word_width)) u_decode (
        .clk, .reset_n, .if_id(if_id_q), .wb(mem_wb_q),
        .ex_is_load(id_ex_q.mem_read), .ex_rd(id_ex_q.rd),
        .decoded(id_ex_d), .stall, .halt_seen
    );

    assign id_ex_flush = redirect || stall;

    pipe_stage_reg #(.payload_t(id_ex_t), .bubble('0)) id_ex (
        .clk, .reset_n, .stall(1'b0), .flush(id_ex_flush), .d(id_ex_d), .q(id_ex_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // EX.
    execute_unit u_execute (
        .id_ex(id_ex_q), .fwd_mem(ex_mem_q), .fwd_wb_value(mem_wb_q.result),
        .fwd_wb_rd(mem_wb_q.rd), .fwd_wb_write(mem_wb_q.reg_write),
        .result(ex_mem_d), .redirect, .redirect_pc
    );

    pipe_stage_reg #(.payload_t(ex_mem_t), .bubble('0)) ex_mem (
        .clk, .reset_n, .stall(1'b0), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // MEM and WB.
    assign dbus.req   = ex_mem_q.mem_read || ex_mem_q.mem_write;
    assign dbus.write = ex_mem_q.mem_write;
    assign dbus.addr  = ex_mem_q.alu_result;
    assign dbus.wdata = ex_mem_q.r_data2;

    mem_arbiter u_arbiter (
        .ibus(ibus.arbiter), .dbus(dbus.arbiter),
        .mem_req, .mem_write, .mem_addr, .mem_wdata, .mem_rdata
    );

    always_comb begin
        mem_wb_d.valid     = ex_mem_q.valid;
        mem_wb_d.result    = ex_mem_q.mem_to_reg ? dbus.rdata : ex_mem_q.alu_result;
        mem_wb_d.rd        = ex_mem_q.rd;
        mem_wb_d.reg_write = ex_mem_q.reg_write;
        mem_wb_d.is_halt   = ex_mem_q.is_halt;
    end

    pipe_stage_reg #(.payload_t(mem_wb_t), .bubble('0)) mem_wb (
        .clk, .reset_n, .stall(1'b0), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halted        <= 1'b0;
            retired_count <= '0;
        end else begin
            if (mem_wb_q.is_halt) begin
                halted <= 1'b1; // Sticky.
            end
            if (mem_wb_q.valid) begin
                retired_count <= retired_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit #(
    parameter int word_width = 16
) (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::if_id_t   if_id,
    input  cpu_pkg::mem_wb_t  wb,
    input  logic              ex_is_load,
    input  cpu_pkg::reg_idx_t ex_rd,
    output cpu_pkg::id_ex_t   decoded,
    output logic              stall,
    output logic              halt_seen
);
    import cpu_pkg::*;

    logic [word_width-1:0] regs [4];
    word_t                 instr;
    opcode_t               opcode;
    func_t                 func;
    reg_idx_t              rs;
    reg_idx_t              rt;
    reg_idx_t              rd;
    word_t                 rs_value;
    word_t                 rt_value;
    logic                  uses_rs;
    logic                  uses_rt;

    assign instr  = if_id.instr;
    assign opcode = opcode_t'(instr[op_lsb +: 4]);
    assign func   = func_t'(instr[func_lsb +: 6]);
    assign rs     = instr[rs_lsb +: 2];
    assign rt     = instr[rt_lsb +: 2];
    assign rd     = instr[rd_lsb +: 2];

    ////////////////////////////////////////////////////////////////////////////
    // Register file.
    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // Write-first, so WB is visible in the same cycle.
    assign rs_value = (wb.reg_write && wb.rd == rs) ? wb.result : regs[rs];
    assign rt_value = (wb.reg_write && wb.rd == rt) ? wb.result : regs[rt];

    ////////////////////////////////////////////////////////////////////////////
    // Control.
    always_comb begin
        decoded          = '0;
        decoded.alu_op   = f_add;
        decoded.rs       = rs;
        decoded.rt       = rt;
        decoded.rs_value = rs_value;
        decoded.rt_value = rt_value;
        decoded.next_pc  = if_id.next_pc;
        decoded.imm      = {{(word_width - imm_width){instr[imm_width-1]}},
                            instr[imm_width-1:0]};
        case (opcode)
            alu_r: begin
                decoded.valid     = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.alu_op    = func;
                decoded.rd        = rd;
            end
            adi: begin
                decoded.valid     = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.alu_src   = 1'b1;
                decoded.rd        = rt;
            end
            lwd: begin
                decoded.valid      = 1'b1;
                decoded.reg_write  = 1'b1;
                decoded.mem_read   = 1'b1;
                decoded.mem_to_reg = 1'b1;
                decoded.alu_src    = 1'b1;
                decoded.rd         = rt;
            end
            swd: begin
                decoded.valid     = 1'b1;
                decoded.mem_write = 1'b1;
                decoded.alu_src   = 1'b1;
            end
            beq, bne: begin
                decoded.valid     = 1'b1;
                decoded.is_branch = 1'b1;
                decoded.branch_ne = (opcode == bne);
            end
            jmp: begin
                decoded.valid   = 1'b1;
                decoded.is_jump = 1'b1;
                decoded.imm     = {if_id.next_pc[word_width-1:jtarget_width],
                                   instr[jtarget_width-1:0]};
            end
            hlt: begin
                decoded.valid   = 1'b1;
                decoded.is_halt = 1'b1;
            end
            default: ; // Bubble.
        endcase
    end

    assign uses_rs = opcode inside {alu_r, adi, lwd, swd, beq, bne};
    assign uses_rt = opcode inside {alu_r, swd, beq, bne};

    // Load result is not ready for EX until the load reaches WB.
    assign stall = ex_is_load && ((uses_rs && rs == ex_rd) || (uses_rt && rt == ex_rd));

    assign halt_seen = (opcode == hlt);

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::ex_mem_t  fwd_mem,
    input  cpu_pkg::word_t    fwd_wb_value,
    input  cpu_pkg::reg_idx_t fwd_wb_rd,
    input  logic              fwd_wb_write,
    output cpu_pkg::ex_mem_t  result,
    output logic              redirect,
    output cpu_pkg::word_t    redirect_pc
);
    import cpu_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t rt_fwd;
    word_t alu_out;
    logic  b_cond;

    // The MEM result is newer than WB and wins.
    function automatic word_t fwd_value(reg_idx_t idx, word_t reg_value);
        if (fwd_mem.reg_write && !fwd_mem.mem_to_reg && fwd_mem.rd == idx) begin
            return fwd_mem.alu_result;
        end else if (fwd_wb_write && fwd_wb_rd == idx) begin
            return fwd_wb_value;
        end
        return reg_value;
    endfunction

    always_comb begin
        op_a   = fwd_value(id_ex.rs, id_ex.rs_value);
        rt_fwd = fwd_value(id_ex.rt, id_ex.rt_value);
    end

    assign op_b = id_ex.alu_src ? id_ex.imm : rt_fwd;

    always_comb begin
        case (id_ex.alu_op)
            f_sub:   alu_out = op_a - op_b;
            f_and:   alu_out = op_a & op_b;
            f_or:    alu_out = op_a | op_b;
            default: alu_out = op_a + op_b;
        endcase
    end

    assign b_cond = (op_a == rt_fwd) ^ id_ex.branch_ne;

    always_comb begin
        result                = '0;
        result.valid          = id_ex.valid;
        result.target_address = id_ex.is_jump ? id_ex.imm : id_ex.next_pc + id_ex.imm;
        result.b_cond         = b_cond;
        result.branch_taken   = (id_ex.is_branch && b_cond) || id_ex.is_jump;
        result.alu_result     = alu_out;
        result.r_data2        = rt_fwd; // Store data.
        result.rd             = id_ex.rd;
        result.mem_read       = id_ex.mem_read;
        result.mem_write      = id_ex.mem_write;
        result.reg_write      = id_ex.reg_write;
        result.mem_to_reg     = id_ex.mem_to_reg;
        result.is_halt        = id_ex.is_halt;
    end

    assign redirect    = result.branch_taken;
    assign redirect_pc = result.target_address;

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int                    word_width = 16,
    parameter logic [word_width-1:0] reset_pc   = '0
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            stall,
    input  logic            redirect,
    input  cpu_pkg::word_t  redirect_pc,
    input  logic            halt_seen,
    mem_bus_if.requester    ibus,
    output cpu_pkg::if_id_t fetched,
    output logic            fetch_valid
);

    logic [word_width-1:0] pc;
    logic [word_width-1:0] pc_plus1;
    logic                  stopped;

    assign pc_plus1 = pc + 1'b1; // Word addressed.

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc      <= reset_pc;
            stopped <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (ibus.grant && !stall) begin
                pc <= pc_plus1;
            end
            // A halt on a flushed path does not count.
            if (halt_seen && !redirect) begin
                stopped <= 1'b1;
            end
        end
    end

    assign ibus.req   = !stopped && !halt_seen;
    assign ibus.write = 1'b0;
    assign ibus.addr  = pc;
    assign ibus.wdata = '0;

    assign fetched.instr   = ibus.rdata;
    assign fetched.next_pc = pc_plus1;
    assign fetch_valid     = ibus.grant;

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    mem_bus_if.arbiter     ibus,
    mem_bus_if.arbiter     dbus,
    output logic           mem_req,
    output logic           mem_write,
    output cpu_pkg::word_t mem_addr,
    output cpu_pkg::word_t mem_wdata,
    input  cpu_pkg::word_t mem_rdata
);

    logic data_sel;

    assign data_sel = dbus.req; // Data always wins.

    assign dbus.grant = dbus.req;
    assign ibus.grant = ibus.req && !data_sel;

    ////////////////////////////////////////////////////////////////////////////
    // Steer the winner to the memory port.
    assign mem_req   = ibus.req || dbus.req;
    assign mem_write = data_sel ? dbus.write : ibus.write;
    assign mem_addr  = data_sel ? dbus.addr  : ibus.addr;
    assign mem_wdata = data_sel ? dbus.wdata : ibus.wdata;

    // Loser sees zero.
    assign dbus.rdata = dbus.grant ? mem_rdata : '0;
    assign ibus.rdata = ibus.grant ? mem_rdata : '0;

endmodule

`default_nettype wire

// File: rtl/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if ();
    import cpu_pkg::*;

    logic  req;
    logic  write;
    word_t addr;
    word_t wdata;
    word_t rdata;   // Valid in the cycle of grant.
    logic  grant;

    modport requester (
        output req, write, addr, wdata,
        input  rdata, grant
    );

    modport arbiter (
        input  req, write, addr, wdata,
        output rdata, grant
    );

endinterface

`default_nettype wire

// File: rtl/pipe_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stage_reg #(
    parameter type      payload_t = logic,
    parameter payload_t bubble    = '0
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Flush beats stall.
    always_ff @(posedge clk) begin
        if (reset_n || flush) begin
            q <= bubble;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: tests/cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts (
    input logic            clk,
    input logic            reset_n,
    input logic            ibus_req,
    input logic            ibus_grant,
    input cpu_pkg::word_t  ibus_addr,
    input logic            dbus_grant,
    input logic            stall,
    input logic            redirect,
    input cpu_pkg::if_id_t if_id_q
);

    int fails = 0;

    // One owner of the memory port per cycle.
    grant_exclusive: assert property (@(posedge clk) disable iff (reset_n)
        !(ibus_grant && dbus_grant))
    else begin
        $error("ibus and dbus granted together");
        fails++;
    end

    ibus_grant_req: assert property (@(posedge clk) disable iff (reset_n)
        ibus_grant |-> ibus_req)
    else begin
        $error("ibus grant without request");
        fails++;
    end

    // A fetch that loses the port asks again for the same word.
    ibus_req_held: assert property (@(posedge clk) disable iff (reset_n)
        (ibus_req && !ibus_grant && !redirect) |=> (ibus_req && $stable(ibus_addr)))
    else begin
        $error("ibus request dropped or moved while not granted");
        fails++;
    end

    // A held IF/ID latch keeps its contents.
    stall_holds: assert property (@(posedge clk) disable iff (reset_n)
        (stall && !redirect) |=> $stable(if_id_q))
    else begin
        $error("IF/ID changed on stall");
        fails++;
    end

endmodule

bind cpu_top cpu_asserts u_asserts (
    .clk, .reset_n,
    .ibus_req(ibus.req), .ibus_grant(ibus.grant), .ibus_addr(ibus.addr),
    .dbus_grant(dbus.grant),
    .stall, .redirect, .if_id_q
);

`default_nettype wire

// File: tests/cpu_tests.dat
# p address word : program image, s address data : expected store, in order
# r count : expected retired instructions, halt included
p 0000 2105 # adi r1 = r0 + 5
p 0001 2603 # adi r2 = r1 + 3
p 0002 16C0 # add r3 = r1 + r2
p 0003 1DC1 # sub r3 = r3 - r1
p 0004 4340 # swd [40] = r3
p 0005 1783 # or  r2 = r1 | r3
p 0006 19C2 # and r3 = r2 & r1
p 0007 4241 # swd [41] = r2
p 0008 4342 # swd [42] = r3
p 0009 3160 # lwd r1 = [60]
p 000A 1780 # add r2 = r1 + r3
p 000B 4243 # swd [43] = r2
p 000C 3361 # lwd r3 = [61]
p 000D 4344 # swd [44] = r3
p 000E 5001 # beq r0 r0 taken
p 000F 4150 # wrong path
p 0010 6601 # bne r1 r2 taken
p 0011 4151 # wrong path
p 0012 5602 # beq r1 r2 not taken
p 0013 21FF # adi r1 = r0 - 1
p 0014 6001 # bne r0 r0 not taken
p 0015 4145 # swd [45] = r1
p 0016 7019 # jmp 19
p 0017 4352 # wrong path
p 0018 4353 # wrong path
p 0019 3245 # lwd r2 = [45]
p 001A 4246 # swd [46] = r2
p 001B 8000 # hlt
p 001C 4154 # after halt
p 0060 1234 # data
p 0061 0F0F # data
s 0040 0008
s 0041 000D
s 0042 0005
s 0043 1239
s 0044 0F0F
s 0045 FFFF
s 0046 FFFF
r 0018

// File: tests/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int mem_words = 4096;

    logic  clk;
    logic  reset_n;
    logic  mem_req;
    logic  mem_write;
    word_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  halted;
    word_t retired_count;

    word_t mem [mem_words];
    word_t exp_addr[$];   // Stores still to come in order.
    word_t exp_data[$];
    word_t final_addr[$]; // Every expected store for the end check.
    word_t final_data[$];
    word_t exp_retired;
    int    errors;
    int    cycles;
    int    limit;
    int    prog_words;

    cpu_top UUT (
        .clk, .reset_n, .mem_req, .mem_write, .mem_addr, .mem_wdata,
        .mem_rdata, .halted, .retired_count
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Behavioral memory with asynchronous read and synchronous write.
    assign mem_rdata = mem[mem_addr[11:0]];

    always @(posedge clk) begin
        if (!reset_n && mem_req && mem_write) begin
            mem[mem_addr[11:0]] <= mem_wdata;
        end
    end

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Store monitor. Every write must be the next one in the list.
    always @(posedge clk) begin
        if (!reset_n && mem_req && mem_write) begin
            if (exp_addr.size() == 0) begin
                $display("Unexpected store of %h to address %h", mem_wdata, mem_addr);
                errors++;
            end else begin
                check("mem_addr", mem_addr, exp_addr[0]);
                check("mem_wdata", mem_wdata, exp_data[0]);
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tagged data file with program words (p), expected stores (s) and retired count (r).
    task automatic load_tests();
        int    fd;
        int    code;
        string tag;
        string rest;
        word_t a;
        word_t d;
        fd = $fopen("tests/cpu_tests.dat", "r");
        if (fd == 0) begin
            $display("Could not open tests/cpu_tests.dat");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "p") begin
                code = $fscanf(fd, "%h %h", a, d);
                mem[a[11:0]] <= d;
                prog_words++;
            end else if (tag == "s") begin
                code = $fscanf(fd, "%h %h", a, d);
                exp_addr.push_back(a);
                exp_data.push_back(d);
                final_addr.push_back(a);
                final_data.push_back(d);
            end else if (tag == "r") begin
                code = $fscanf(fd, "%h", exp_retired);
            end else begin
                code = $fgets(rest, fd); // Comment up to end of line.
            end
        end
        $fclose(fd);
    endtask

    initial begin
        reset_n     = 1'b1; // Active high.
        errors      = 0;
        cycles      = 0;
        prog_words  = 0;
        exp_retired = '0;
        // Unloaded words hold their own address, which decodes as a bubble.
        for (int i = 0; i < mem_words; i++) begin
            mem[i] <= word_t'(i);
        end
        load_tests();
        limit = 40 * prog_words + 100;

        repeat (5) @(posedge clk);
        reset_n <= 1'b0;

        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end

        if (!halted) begin
            $display("Timeout: the processor never halted within %0d cycles", limit);
            errors++;
        end else begin
            repeat (3) @(negedge clk);
            check("mem_req", {15'b0, mem_req}, 16'h0000);
            check("retired_count", retired_count, exp_retired);
            if (exp_addr.size() != 0) begin
                $display("%0d expected stores never happened", exp_addr.size());
                errors++;
            end
            foreach (final_addr[i]) begin
                check("final memory word", mem[final_addr[i][11:0]], final_data[i]);
            end
        end

        errors += UUT.u_asserts.fails;

        $display("Errors: %0d after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/pipe_stage_reg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/mem_arbiter.sv
rtl/cpu_top.sv
tests/cpu_asserts.sv
tests/tb_cpu.sv
